// File: hdl/cpuPkg.sv
package cpuPkg;

	////////////////////////////////////////////////////////////
	// Words and register indices

	localparam int wordWidth = 16;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [1:0] regIdxT;                  // 0 is zero reg, 1..3 are A, B, C

	// Stage codes go straight to the LEDs
	typedef enum logic [3:0] {
		fetch     = 4'b0000,
		decode    = 4'b0001,
		operands  = 4'b1000,
		execute   = 4'b0011,
		writeBack = 4'b0101,
		recover   = 4'b0110,
		halt      = 4'b1111
	} stageT;

	// Cycles spent in each stage
	localparam int fetchLen     = 6;
	localparam int decodeLen    = 2;
	localparam int operandsLen  = 2;
	localparam int executeLen   = 4;
	localparam int writeBackLen = 3;
	localparam int recoverLen   = 2;

	// Strobe positions inside their stage
	localparam int marCycle     = 0;            // fetch
	localparam int romCycle     = 1;            // fetch
	localparam int irCycle      = 3;            // fetch
	localparam int pcCycle      = 4;            // fetch
	localparam int operandCycle = 0;            // operands
	localparam int aluCycle     = 0;            // execute
	localparam int resultCycle  = 2;            // execute
	localparam int writeCycle   = 1;            // writeBack

	////////////////////////////////////////////////////////////
	// Instruction format

	typedef struct packed {
		logic [3:0] opcode;
		regIdxT     rs;
		regIdxT     rt;
		regIdxT     rd;
		logic [1:0] shamt;
		logic [3:0] funct;
	} instrT;

	localparam logic [3:0] opRType = 4'd0;
	localparam logic [3:0] opHalt  = 4'd15;

	typedef enum logic [2:0] {
		aluAnd     = 3'b000,
		aluOr      = 3'b001,
		aluAdd     = 3'b010,
		aluOne     = 3'b011,                      // constant 1
		aluSub     = 3'b110,
		aluSetLess = 3'b111
	} aluOpT;

	localparam logic [3:0] fnAdd     = 4'd0;
	localparam logic [3:0] fnSub     = 4'd2;
	localparam logic [3:0] fnAnd     = 4'd4;
	localparam logic [3:0] fnOr      = 4'd5;
	localparam logic [3:0] fnSetLess = 4'd10;

	////////////////////////////////////////////////////////////
	// Program store

	localparam int pcStep      = 4;             // byte addressed
	localparam int pcShift     = $clog2(pcStep);
	localparam int romDepth    = 16;
	localparam int romAddrBits = $clog2(romDepth);

	// Funct 15 is unlisted, so it gives 1
	localparam wordT romImage [0:romDepth-1] = '{
		{opRType, 2'd0, 2'd0, 2'd1, 2'd0, 4'd15},     // A = 1
		{opRType, 2'd0, 2'd0, 2'd3, 2'd0, 4'd15},     // C = 1
		{opRType, 2'd1, 2'd3, 2'd2, 2'd0, fnAdd},     // B = A + C
		{opRType, 2'd3, 2'd1, 2'd2, 2'd0, fnSub},     // B = C - A
		{opRType, 2'd0, 2'd0, 2'd2, 2'd0, 4'd15},     // B = 1
		{opRType, 2'd0, 2'd0, 2'd1, 2'd0, 4'd15},     // A = 1
		{opRType, 2'd0, 2'd0, 2'd2, 2'd0, 4'd15},     // B = 1
		{opRType, 2'd1, 2'd3, 2'd3, 2'd0, fnAdd},     // C = A + C
		{opRType, 2'd1, 2'd3, 2'd3, 2'd0, fnAdd},     // C = A + C again
		{opRType, 2'd3, 2'd2, 2'd1, 2'd0, fnSub},     // A = C - B
		{opRType, 2'd1, 2'd3, 2'd3, 2'd0, fnAnd},     // C = A & C
		{opRType, 2'd2, 2'd1, 2'd2, 2'd0, fnOr},      // B = B | A
		{opRType, 2'd1, 2'd2, 2'd3, 2'd0, fnSetLess}, // C = A < B
		{opHalt, 12'd0},                              // stop here
		16'd0,
		16'd0
	};

	////////////////////////////////////////////////////////////
	// Control strobes and display select

	typedef struct packed {
		logic loadMar;
		logic readRom;
		logic loadIr;
		logic incPc;
		logic latchOperands;
		logic aluRun;
		logic latchResult;
		logic regWrite;
	} ctrlT;

	typedef logic [2:0] dispSelT;

	localparam dispSelT dispInstr  = 3'd0;
	localparam dispSelT dispResult = 3'd1;
	localparam dispSelT dispA      = 3'd2;
	localparam dispSelT dispB      = 3'd3;
	localparam dispSelT dispC      = 3'd4;
	localparam dispSelT dispPc     = 3'd5;   // 6 and 7 show zero

endpackage

// File: hdl/stageTimer.sv
`timescale 1ns/100ps

module stageTimer import cpuPkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  stageT      stage,
	input  logic       run,
	output logic [2:0] cycleIdx,
	output logic       stageDone
);

	stageT      prevStage;   // stage seen last cycle
	logic [2:0] cnt;
	logic [2:0] lastIdx;     // final cycle of current stage

	always_comb
	begin
		case (stage)
			fetch:     lastIdx = 3'(fetchLen - 1);
			decode:    lastIdx = 3'(decodeLen - 1);
			operands:  lastIdx = 3'(operandsLen - 1);
			execute:   lastIdx = 3'(executeLen - 1);
			writeBack: lastIdx = 3'(writeBackLen - 1);
			recover:   lastIdx = 3'(recoverLen - 1);
			default:   lastIdx = 3'd0;              // halt sits on cycle 0
		endcase
	end

	// Fresh stage always starts from 0
	assign cycleIdx  = (stage != prevStage) ? 3'd0 : cnt;
	assign stageDone = (cycleIdx == lastIdx);

	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
		begin
			prevStage <= fetch;
			cnt       <= 3'd0;
		end
		else
		begin
			prevStage <= stage;
			if (!stageDone)
				cnt <= cycleIdx + 3'd1;
			else if (run)
				cnt <= 3'd0;        // stage moves on this edge
			else
				cnt <= cycleIdx;    // waiting for run, freeze
		end
	end

endmodule

// File: hdl/controlFsm.sv
`timescale 1ns/100ps

module controlFsm import cpuPkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       run,
	input  instrT      instr,
	input  logic [2:0] cycleIdx,
	input  logic       stageDone,
	output stageT      stage,
	output ctrlT       ctrl,
	output aluOpT      aluOp
);

	stageT      nextStage;
	stageT      lastStage;   // slot of previous cycle
	logic [2:0] lastIdx;
	logic       repeatSlot;  // same stage and cycle as before

	////////////////////////////////////////////////////////////
	// Stage sequencing

	always_comb
	begin
		nextStage = stage;
		if (stageDone && run)
		begin
			case (stage)
				fetch:     nextStage = decode;
				decode:    nextStage = (instr.opcode == opRType) ? operands : halt;
				operands:  nextStage = execute;
				execute:   nextStage = writeBack;
				writeBack: nextStage = recover;
				recover:   nextStage = fetch;
				default:   nextStage = halt;     // only reset leaves halt
			endcase
		end
	end

	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
			stage <= fetch;
		else
			stage <= nextStage;
	end

	////////////////////////////////////////////////////////////
	// One-shot strobes

	// Reset state counts as already visited
	// MAR and PC are both 0 then, so the skipped loadMar costs nothing
	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
		begin
			lastStage <= fetch;
			lastIdx   <= 3'd0;
		end
		else
		begin
			lastStage <= stage;
			lastIdx   <= cycleIdx;
		end
	end

	assign repeatSlot = (stage == lastStage) && (cycleIdx == lastIdx);

	always_comb
	begin
		ctrl = '0;
		if (!repeatSlot)
		begin
			case (stage)
				fetch:
				begin
					ctrl.loadMar = (cycleIdx == 3'(marCycle));   // MAR <= PC
					ctrl.readRom = (cycleIdx == 3'(romCycle));
					ctrl.loadIr  = (cycleIdx == 3'(irCycle));
					ctrl.incPc   = (cycleIdx == 3'(pcCycle));
				end
				operands:
					ctrl.latchOperands = (cycleIdx == 3'(operandCycle));
				execute:
				begin
					ctrl.aluRun      = (cycleIdx == 3'(aluCycle));
					ctrl.latchResult = (cycleIdx == 3'(resultCycle));
				end
				writeBack:
					// Zero register is never written
					ctrl.regWrite = (cycleIdx == 3'(writeCycle)) && (instr.rd != 2'd0);
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Funct to ALU op, captured by executeUnit in operands

	always_comb
	begin
		case (instr.funct)
			fnAdd:     aluOp = aluAdd;
			fnSub:     aluOp = aluSub;
			fnAnd:     aluOp = aluAnd;
			fnOr:      aluOp = aluOr;
			fnSetLess: aluOp = aluSetLess;
			default:   aluOp = aluOne;
		endcase
	end

endmodule

// File: hdl/programRom.sv
`timescale 1ns/100ps

module programRom import cpuPkg::*; (
	input  logic CLK,
	input  logic rst,
	input  ctrlT ctrl,
	input  wordT pc,
	output wordT romWord
);

	wordT                         mar;       // memory address register
	logic [wordWidth-pcShift-1:0] wordIdx;   // byte address to word index

	assign wordIdx = mar[wordWidth-1:pcShift];

	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
		begin
			mar     <= '0;
			romWord <= '0;
		end
		else
		begin
			if (ctrl.loadMar)
				mar <= pc;
			if (ctrl.readRom)
			begin
				if (wordIdx < romDepth)
					romWord <= romImage[wordIdx[romAddrBits-1:0]];
				else
					romWord <= '0;   // past the image
			end
		end
	end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  ctrlT  ctrl,
	input  instrT instr,
	input  wordT  writeData,
	output wordT  rsData,
	output wordT  rtData,
	output wordT  regA,
	output wordT  regB,
	output wordT  regC
);

	wordT gpr [1:3];   // A, B, C

	// Index 0 is the hardwired zero
	function automatic wordT readPort(input regIdxT idx);
		wordT val;
		if (idx == 2'd0)
			val = '0;
		else
			val = gpr[idx];
		return val;
	endfunction

	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i <= 3; i++)
				gpr[i] <= '0;
		end
		else if (ctrl.regWrite && (instr.rd != 2'd0))
			gpr[instr.rd] <= writeData;   // rd picks the target
	end

	// Read ports follow register contents as well as the indices
	always_comb
	begin
		rsData = readPort(instr.rs);
		rtData = readPort(instr.rt);
	end

	// Straight views for the display mux
	assign regA = gpr[1];
	assign regB = gpr[2];
	assign regC = gpr[3];

endmodule

// File: hdl/executeUnit.sv
`timescale 1ns/100ps

module executeUnit import cpuPkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  ctrlT  ctrl,
	input  aluOpT aluOp,
	input  wordT  romWord,
	input  wordT  rsData,
	input  wordT  rtData,
	output instrT instr,
	output wordT  pc,
	output wordT  result
);

	wordT  srcA;     // rs latch
	wordT  srcB;     // rt latch
	aluOpT opLatch;
	wordT  aluOut;   // registered ALU stage
	wordT  aluNext;

	////////////////////////////////////////////////////////////
	// Instruction register and program counter

	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
		begin
			instr <= '0;
			pc    <= '0;
		end
		else
		begin
			if (ctrl.loadIr)
				instr <= instrT'(romWord);
			if (ctrl.incPc)
				pc <= pc + wordT'(pcStep);
		end
	end

	////////////////////////////////////////////////////////////
	// Operand latches, filled in operands stage

	always_ff @(posedge CLK)
	begin
		if (ctrl.latchOperands)
		begin
			srcA    <= rsData;
			srcB    <= rtData;
			opLatch <= aluOp;
		end
	end

	////////////////////////////////////////////////////////////
	// ALU

	always_comb
	begin
		case (opLatch)
			aluAnd:     aluNext = srcA & srcB;
			aluOr:      aluNext = srcA | srcB;
			aluAdd:     aluNext = srcA + srcB;
			aluSub:     aluNext = srcA - srcB;
			aluSetLess: aluNext = wordT'(srcA < srcB);   // unsigned compare
			default:    aluNext = wordT'(1);
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (ctrl.aluRun)
			aluOut <= aluNext;
	end

	// Result register feeds write-back and display
	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
			result <= '0;
		else if (ctrl.latchResult)
			result <= aluOut;
	end

endmodule

// File: hdl/stepProcessor.sv
`timescale 1ns/100ps

module stepProcessor import cpuPkg::*; (
	input  logic    CLK,
	input  logic    rst,
	input  logic    run,
	input  dispSelT displaySel,
	output stageT   stage,
	output wordT    displayOut
);

	logic [2:0] cycleIdx;
	logic       stageDone;
	ctrlT       ctrl;
	aluOpT      aluOp;
	instrT      instr;
	wordT       pc;
	wordT       romWord;
	wordT       result;
	wordT       rsData;
	wordT       rtData;
	wordT       regA;
	wordT       regB;
	wordT       regC;

	////////////////////////////////////////////////////////////
	// Sequencing

	stageTimer timer (
		.CLK       (CLK),
		.rst       (rst),
		.stage     (stage),
		.run       (run),
		.cycleIdx  (cycleIdx),
		.stageDone (stageDone)
	);

	controlFsm fsm (
		.CLK       (CLK),
		.rst       (rst),
		.run       (run),
		.instr     (instr),
		.cycleIdx  (cycleIdx),
		.stageDone (stageDone),
		.stage     (stage),
		.ctrl      (ctrl),
		.aluOp     (aluOp)
	);

	////////////////////////////////////////////////////////////
	// Datapath

	programRom rom (
		.CLK     (CLK),
		.rst     (rst),
		.ctrl    (ctrl),
		.pc      (pc),
		.romWord (romWord)
	);

	regFile regs (
		.CLK       (CLK),
		.rst       (rst),
		.ctrl      (ctrl),
		.instr     (instr),
		.writeData (result),   // write-back only from ALU result
		.rsData    (rsData),
		.rtData    (rtData),
		.regA      (regA),
		.regB      (regB),
		.regC      (regC)
	);

	executeUnit exec (
		.CLK     (CLK),
		.rst     (rst),
		.ctrl    (ctrl),
		.aluOp   (aluOp),
		.romWord (romWord),
		.rsData  (rsData),
		.rtData  (rtData),
		.instr   (instr),
		.pc      (pc),
		.result  (result)
	);

	// Display word, one cycle behind displaySel
	always_ff @(posedge CLK or negedge rst)
	begin
		if (!rst)
			displayOut <= '0;
		else
		begin
			case (displaySel)
				dispInstr:  displayOut <= wordT'(instr);
				dispResult: displayOut <= result;
				dispA:      displayOut <= regA;
				dispB:      displayOut <= regB;
				dispC:      displayOut <= regC;
				dispPc:     displayOut <= pc;
				default:    displayOut <= '0;
			endcase
		end
	end

endmodule

// File: dv/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Architectural state after a whole instruction
typedef struct packed {
	wordT  regA;
	wordT  regB;
	wordT  regC;
	wordT  pc;
	instrT instr;
	wordT  result;
} archStateT;

// Program word at a byte address
function automatic wordT fetchWordRef(input wordT addr);
	int idx;
	idx = int'(addr) / pcStep;
	if (idx < romDepth)
		return romImage[idx];
	return '0;                               // past the image
endfunction

function automatic wordT readRegRef(input archStateT s, input regIdxT idx);
	case (idx)
		2'd1:    return s.regA;
		2'd2:    return s.regB;
		2'd3:    return s.regC;
		default: return '0;                  // zero register
	endcase
endfunction

function automatic wordT aluRef(input logic [3:0] funct, input wordT a, input wordT b);
	case (funct)
		fnAdd:     return a + b;
		fnSub:     return a - b;
		fnAnd:     return a & b;
		fnOr:      return a | b;             // both sources
		fnSetLess: return (a < b) ? wordT'(1) : wordT'(0);
		default:   return wordT'(1);         // unknown funct
	endcase
endfunction

// One instruction, fetch through write-back
function automatic archStateT stepRef(input archStateT s);
	archStateT n;
	wordT      res;
	n       = s;
	n.instr = instrT'(fetchWordRef(s.pc));
	n.pc    = s.pc + wordT'(pcStep);
	if (n.instr.opcode == opRType)
	begin
		res      = aluRef(n.instr.funct, readRegRef(s, n.instr.rs), readRegRef(s, n.instr.rt));
		n.result = res;
		case (n.instr.rd)
			2'd1:    n.regA = res;
			2'd2:    n.regB = res;
			2'd3:    n.regC = res;
			default: ;                       // rd 0 is dropped
		endcase
	end
	return n;
endfunction

`endif

// File: dv/stepProcessorTb.sv
`timescale 1ns/100ps

module stepProcessorTb import cpuPkg::*; ();

	`include "refModel.svh"

	localparam int holdPerStop = 20;   // drop, sweep, hold, resume
	localparam int cycleLimit  = 2 * romDepth * 19 + romDepth * holdPerStop;

	logic    CLK;
	logic    rst;
	logic    run;
	dispSelT displaySel;
	stageT   stage;
	wordT    displayOut;

	archStateT refState;         // expected state from the stimulus
	logic      displayCheckOn;   // compare display and stage each cycle
	stageT     holdStage;
	dispSelT   selAtEdge;        // select the DUT just sampled

	stageT curStage;             // stage monitor
	int    stageCycles;
	logic  prevRun;              // run during the previous cycle
	wordT  monPc;
	instrT monInstr;

	int   cycleCount = 0;
	int   stopCount;
	logic halted;

	stepProcessor UUT (
		.CLK        (CLK),
		.rst        (rst),
		.run        (run),
		.displaySel (displaySel),
		.stage      (stage),
		.displayOut (displayOut)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////
	// Reporting and compare

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT expected);
		if (got !== expected)
			stopOnError($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
				$time, name, got, expected));
	endtask

	task automatic checkStage(input string name, input stageT got, input stageT expected);
		if (got !== expected)
			stopOnError($sformatf("CHECK FAILED at time %0t: %s is %s (%b), expected %s (%b)",
				$time, name, got.name(), got, expected.name(), expected));
	endtask

	function automatic string displayName(input dispSelT sel);
		case (sel)
			dispInstr:  return "displayOut(instr)";
			dispResult: return "displayOut(result)";
			dispA:      return "displayOut(A)";
			dispB:      return "displayOut(B)";
			dispC:      return "displayOut(C)";
			dispPc:     return "displayOut(pc)";
			default:    return "displayOut(zero)";
		endcase
	endfunction

	function automatic wordT displayRef(input archStateT s, input dispSelT sel);
		case (sel)
			dispInstr:  return wordT'(s.instr);
			dispResult: return s.result;
			dispA:      return s.regA;
			dispB:      return s.regB;
			dispC:      return s.regC;
			dispPc:     return s.pc;
			default:    return '0;
		endcase
	endfunction

	function automatic stageT nextStageRef(input stageT cur, input instrT ins);
		case (cur)
			fetch:     return decode;
			decode:    return (ins.opcode == opRType) ? operands : halt;
			operands:  return execute;
			execute:   return writeBack;
			writeBack: return recover;
			recover:   return fetch;
			default:   return halt;              // halt never leaves
		endcase
	endfunction

	function automatic int stageLenRef(input stageT st);
		case (st)
			fetch:     return fetchLen;
			decode:    return decodeLen;
			operands:  return operandsLen;
			execute:   return executeLen;
			writeBack: return writeBackLen;
			recover:   return recoverLen;
			default:   return 0;
		endcase
	endfunction

	always @(posedge CLK)
		selAtEdge <= displaySel;

	// Stage monitor plus held-state compare
	always @(negedge CLK)
	begin
		if (!rst)
		begin
			checkStage("stage in reset", stage, fetch);
			curStage    = fetch;
			stageCycles = 0;
			prevRun     = run;
			monPc       = '0;
		end
		else
		begin
			if (stage != curStage)
			begin
				if (curStage != halt && (stageCycles < stageLenRef(curStage) || !prevRun))
					stopOnError($sformatf("Stage %s ended after %0d cycles, too early",
						curStage.name(), stageCycles));
				if (curStage == fetch)
				begin
					monInstr = instrT'(fetchWordRef(monPc));   // word just fetched
					monPc    = monPc + wordT'(pcStep);
				end
				checkStage("stage", stage, nextStageRef(curStage, monInstr));
				curStage    = stage;
				stageCycles = 0;
			end
			else if (curStage != halt && prevRun && stageCycles >= stageLenRef(curStage))
				stopOnError($sformatf("Stage %s stayed past %0d cycles with run high",
					curStage.name(), stageCycles));
			stageCycles = stageCycles + 1;
			prevRun     = run;
			if (displayCheckOn)
			begin
				checkStage("stage while held", stage, holdStage);
				checkWord(displayName(selAtEdge), displayOut, displayRef(refState, selAtEdge));
			end
		end
	end

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			stopOnError($sformatf("Timeout, run not finished after %0d cycles", cycleLimit));
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	// Reset, then sweep the display while fetch holds
	task automatic resetAndCheckZero();
		dispSelT order [0:6];
		order = '{dispPc, dispResult, dispA, dispB, dispC, 3'd6, 3'd7};
		@(posedge CLK);
		rst            <= 1'b0;
		run            <= 1'b0;
		displaySel     <= dispInstr;
		displayCheckOn <= 1'b0;
		repeat (2) @(posedge CLK);
		rst            <= 1'b1;
		refState       = '0;
		holdStage      <= fetch;
		displayCheckOn <= 1'b1;
		// Instr and pc go first, before fetch loads them
		for (int i = 0; i < 7; i++)
		begin
			@(posedge CLK);
			displaySel <= order[i];
		end
		repeat (2) @(posedge CLK);
		displayCheckOn <= 1'b0;
		run            <= 1'b1;
	endtask

	// First cycle of the next recover or halt
	task automatic waitForHold();
		do
			@(negedge CLK);
		while (stage == recover);        // still leaving the last stop
		while (stage != recover && stage != halt)
			@(negedge CLK);
	endtask

	// Drop run, walk all selects, hold, resume
	task automatic holdAndSweep(input stageT st, input int extra);
		@(posedge CLK);
		run            <= 1'b0;
		holdStage      <= st;
		displayCheckOn <= 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			@(posedge CLK);
			displaySel <= dispSelT'(i);
		end
		repeat (extra) @(posedge CLK);
		@(posedge CLK);
		run            <= 1'b1;
		displayCheckOn <= 1'b0;
	endtask

	initial
	begin
		rst            = 1'b0;
		run            = 1'b0;
		displaySel     = dispInstr;
		displayCheckOn = 1'b0;
		holdStage      = fetch;
		selAtEdge      = dispInstr;
		refState       = '0;
		stopCount      = 0;
		halted         = 1'b0;

		resetAndCheckZero();

		while (!halted)
		begin
			waitForHold();
			refState = stepRef(refState);
			halted   = (refState.instr.opcode != opRType);
			holdAndSweep(halted ? halt : recover, 1 + (stopCount * 3) % 5);
			stopCount = stopCount + 1;
		end

		// Halt only leaves through reset, even with run high
		repeat (4) @(posedge CLK);
		resetAndCheckZero();
		repeat (4) @(posedge CLK);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: files.f
+incdir+dv
hdl/cpuPkg.sv
hdl/stageTimer.sv
hdl/controlFsm.sv
hdl/programRom.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/stepProcessor.sv
dv/stepProcessorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the step processor testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module stepProcessorTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VstepProcessorTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi
echo "Simulation passed"
exit 0
